/* rtl/systolic_geom_pkg.sv */
package systolic_geom_pkg;

	// PE array shape
	localparam int DEF_PE_ROWS = 4;
	localparam int DEF_PE_COLS = 4;

	// Width of the M, K and N job sizes
	localparam int DEF_SIZE_W = 5;

	// Every SRAM address uses this width
	localparam int DEF_ADDR_W = 10; // Operand and output SRAMs alike

endpackage

/* rtl/mm_ctrl_pkg.sv */
package mm_ctrl_pkg;

	// Controller phases
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0, // Waiting for start
		ST_COMPUTE = 2'd1, // Streaming operands into the array
		ST_FLUSH   = 2'd2  // Draining accumulators to the output SRAM
	} ctrl_state_t;

endpackage

/* rtl/tile_fsm.sv */
`timescale 1ns/10ps

module tile_fsm
	import mm_ctrl_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTn,
	input  logic        start,
	input  logic        stall,
	input  logic        compute_done,
	input  logic        flush_done,
	input  logic        last_tile,
	output ctrl_state_t state,
	output logic        load_job,
	output logic        to_flush,
	output logic        next_tile,
	output logic        finished,
	output logic        is_computing,
	output logic        is_flushing
);

	ctrl_state_t state_nxt;

	assign is_computing = (state == ST_COMPUTE);
	assign is_flushing  = (state == ST_FLUSH);

	// Strobes never fire while stalled
	assign load_job  = (state == ST_IDLE) && start && !stall; // Start only counts when idle
	assign to_flush  = is_computing && compute_done && !stall;
	assign next_tile = is_flushing && flush_done && !last_tile && !stall;
	assign finished  = is_flushing && flush_done && last_tile && !stall; // Last flush cycle

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:    state_nxt = load_job ? ST_COMPUTE : ST_IDLE;
			ST_COMPUTE: state_nxt = to_flush ? ST_FLUSH : ST_COMPUTE;
			ST_FLUSH: begin
				if (next_tile)
					state_nxt = ST_COMPUTE; // Straight into the next tile
				else if (finished)
					state_nxt = ST_IDLE;
			end
			default:    state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTn)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	// Phase ends only arrive in the phase that owns them
	assert property (@(posedge CLK) disable iff (!RSTn)
		compute_done |-> (state == ST_COMPUTE));
	assert property (@(posedge CLK) disable iff (!RSTn)
		flush_done |-> (state == ST_FLUSH));

endmodule

/* rtl/phase_counter.sv */
`timescale 1ns/10ps

module phase_counter
	import mm_ctrl_pkg::*;
#(
	parameter int PE_ROWS = 4,
	parameter int PE_COLS = 4,
	parameter int SIZE_W  = 5
) (
	input  logic                                 CLK,
	input  logic                                 RSTn,
	input  logic                                 stall,
	input  ctrl_state_t                          state,
	input  logic                                 load_job,
	input  logic                                 to_flush,
	input  logic                                 next_tile,
	input  logic [SIZE_W-1:0]                    k_in,
	input  logic [$clog2(PE_ROWS+1)-1:0]         act_rows,
	input  logic [$clog2(PE_COLS+1)-1:0]         act_cols,
	output logic [((SIZE_W > $clog2(PE_ROWS+PE_COLS)) ?
	               SIZE_W : $clog2(PE_ROWS+PE_COLS)):0] count,
	output logic [SIZE_W-1:0]                    k_size,
	output logic                                 compute_done,
	output logic                                 flush_done
);

	localparam int SUM_W = $clog2(PE_ROWS + PE_COLS);
	localparam int CNT_W = ((SIZE_W > SUM_W) ? SIZE_W : SUM_W) + 1; // Holds K + ar + ac
	localparam logic [CNT_W-1:0] FLUSH_LAST = CNT_W'(PE_ROWS - 1);

	logic [CNT_W-1:0] compute_end;

	// Last compute cycle index, skew of both edges included
	assign compute_end = CNT_W'(k_size) + CNT_W'(act_rows) + CNT_W'(act_cols) - CNT_W'(2);

	assign compute_done = (state == ST_COMPUTE) && (count == compute_end);
	assign flush_done   = (state == ST_FLUSH) && (count == FLUSH_LAST); // One cycle per row

	always_ff @(posedge CLK) begin
		if (load_job)
			k_size <= k_in; // Kept for the whole job
	end

	always_ff @(posedge CLK) begin
		if (!RSTn)
			count <= '0;
		else if (!stall) begin
			if (state == ST_IDLE || to_flush || next_tile)
				count <= '0; // Every phase starts at zero
			else
				count <= count + 1'b1;
		end
	end

	assert property (@(posedge CLK) disable iff (!RSTn)
		(state == ST_COMPUTE) |-> (count <= compute_end));
	assert property (@(posedge CLK) disable iff (!RSTn)
		(state == ST_FLUSH) |-> (count <= FLUSH_LAST));

endmodule

/* rtl/tile_sequencer.sv */
`timescale 1ns/10ps

module tile_sequencer #(
	parameter int PE_ROWS = 4,
	parameter int PE_COLS = 4,
	parameter int SIZE_W  = 5
) (
	input  logic                         CLK,
	input  logic                         RSTn,
	input  logic                         load_job,
	input  logic                         next_tile,
	input  logic [SIZE_W-1:0]            m_in,
	input  logic [SIZE_W-1:0]            n_in,
	output logic [SIZE_W-1:0]            tile_row,
	output logic [SIZE_W-1:0]            tile_col,
	output logic [SIZE_W-1:0]            num_tile_rows,
	output logic [SIZE_W-1:0]            num_tile_cols,
	output logic [$clog2(PE_ROWS+1)-1:0] act_rows,
	output logic [$clog2(PE_COLS+1)-1:0] act_cols,
	output logic                         last_tile
);

	localparam int RW = $clog2(PE_ROWS + 1);
	localparam int CW = $clog2(PE_COLS + 1);
	localparam int EW = SIZE_W + ((RW > CW) ? RW : CW); // Room for the rounding add

	logic [EW-1:0]     m_round;
	logic [EW-1:0]     n_round;
	logic [SIZE_W-1:0] n_q;       // N for reloading the column budget
	logic [SIZE_W-1:0] rows_left; // Rows of the output not yet covered
	logic [SIZE_W-1:0] cols_left; // Columns left in the current tile row
	logic              col_wrap;

	// Ceiling division for the tile counts
	assign m_round = EW'(m_in) + EW'(PE_ROWS - 1);
	assign n_round = EW'(n_in) + EW'(PE_COLS - 1);

	// Edge tiles only get what is left
	assign act_rows = (EW'(rows_left) >= EW'(PE_ROWS)) ? RW'(PE_ROWS) : RW'(rows_left);
	assign act_cols = (EW'(cols_left) >= EW'(PE_COLS)) ? CW'(PE_COLS) : CW'(cols_left);

	assign col_wrap  = (tile_col == num_tile_cols - 1'b1);
	assign last_tile = col_wrap && (tile_row == num_tile_rows - 1'b1);

	always_ff @(posedge CLK) begin
		if (load_job)
			n_q <= n_in;
	end

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			tile_row      <= '0;
			tile_col      <= '0;
			num_tile_rows <= '0;
			num_tile_cols <= '0;
			rows_left     <= '0;
			cols_left     <= '0;
		end else if (load_job) begin
			tile_row      <= '0;
			tile_col      <= '0; // First tile is the top left one
			num_tile_rows <= SIZE_W'(m_round / EW'(PE_ROWS));
			num_tile_cols <= SIZE_W'(n_round / EW'(PE_COLS));
			rows_left     <= m_in;
			cols_left     <= n_in;
		end else if (next_tile) begin
			if (col_wrap) begin
				tile_col  <= '0; // Back to column 0, one tile row down
				tile_row  <= tile_row + 1'b1;
				cols_left <= n_q;
				rows_left <= rows_left - SIZE_W'(PE_ROWS);
			end else begin
				tile_col  <= tile_col + 1'b1;
				cols_left <= cols_left - SIZE_W'(PE_COLS);
			end
		end
	end

endmodule

/* rtl/sram_addr_gen.sv */
`timescale 1ns/10ps

module sram_addr_gen
	import mm_ctrl_pkg::*;
#(
	parameter int PE_ROWS = 4,
	parameter int PE_COLS = 4,
	parameter int SIZE_W  = 5,
	parameter int ADDR_W  = 10
) (
	input  logic                                 CLK,
	input  logic                                 RSTn,
	input  logic                                 stall,
	input  ctrl_state_t                          state,
	input  logic                                 load_job,
	input  logic                                 to_flush,
	input  logic                                 next_tile,
	input  logic [((SIZE_W > $clog2(PE_ROWS+PE_COLS)) ?
	               SIZE_W : $clog2(PE_ROWS+PE_COLS)):0] count,
	input  logic [SIZE_W-1:0]                    tile_row,
	input  logic [SIZE_W-1:0]                    tile_col,
	input  logic [SIZE_W-1:0]                    num_tile_rows,
	input  logic [SIZE_W-1:0]                    num_tile_cols,
	input  logic [$clog2(PE_ROWS+1)-1:0]         act_rows,
	input  logic [$clog2(PE_COLS+1)-1:0]         act_cols,
	output logic [ADDR_W-1:0]                    opnd1_addr,
	output logic [ADDR_W-1:0]                    opnd2_addr,
	output logic [ADDR_W-1:0]                    out_addr,
	output logic                                 out_we_n,
	output logic [PE_COLS-1:0]                   out_lane_en
);

	localparam int SUM_W = $clog2(PE_ROWS + PE_COLS);
	localparam int CNT_W = ((SIZE_W > SUM_W) ? SIZE_W : SUM_W) + 1;
	localparam int CW    = $clog2(PE_COLS + 1);
	localparam logic [CNT_W-1:0] FLUSH_LAST = CNT_W'(PE_ROWS - 1);

	logic [ADDR_W-1:0] opnd1_ofs;     // c * nrt
	logic [ADDR_W-1:0] opnd2_ofs;     // c * nct
	logic [ADDR_W-1:0] tile_row_base; // tr * PE_ROWS * nct
	logic [ADDR_W-1:0] out_row_addr;
	logic              flushing;

	assign flushing = (state == ST_FLUSH);

	// Operand 1 is column major, so one step of K moves by the tile row count
	assign opnd1_addr = ADDR_W'(tile_row) + opnd1_ofs;
	assign opnd2_addr = ADDR_W'(tile_col) + opnd2_ofs;
	assign out_addr   = out_row_addr;

	// Short tiles write only their bottom rows
	assign out_we_n = !(flushing && (count >= CNT_W'(PE_ROWS) - CNT_W'(act_rows)));

	for (genvar j = 0; j < PE_COLS; j++) begin : g_lane
		assign out_lane_en[j] = flushing && (CW'(j) < act_cols);
	end

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			opnd1_ofs <= '0;
			opnd2_ofs <= '0;
		end else if (!stall) begin
			if (load_job || next_tile) begin
				opnd1_ofs <= '0; // New tile restarts at its own id
				opnd2_ofs <= '0;
			end else if (state == ST_COMPUTE) begin
				opnd1_ofs <= opnd1_ofs + ADDR_W'(num_tile_rows);
				opnd2_ofs <= opnd2_ofs + ADDR_W'(num_tile_cols);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			if (load_job)
				tile_row_base <= '0;
			else if (next_tile && (tile_col == num_tile_cols - 1'b1))
				tile_row_base <= tile_row_base + ADDR_W'(PE_ROWS) * ADDR_W'(num_tile_cols);
			if (to_flush)
				out_row_addr <= tile_row_base + ADDR_W'(tile_col); // Row 0 of this tile
			else if (!out_we_n)
				out_row_addr <= out_row_addr + ADDR_W'(num_tile_cols); // Next output row
		end
	end

	// Once writing starts it runs to the end of the flush
	assert property (@(posedge CLK) disable iff (!RSTn)
		(!out_we_n && !stall && count != FLUSH_LAST) |=> (!out_we_n && flushing));

endmodule

/* rtl/fifo_enable_gen.sv */
`timescale 1ns/10ps

module fifo_enable_gen
	import mm_ctrl_pkg::*;
#(
	parameter int PE_ROWS = 4,
	parameter int PE_COLS = 4,
	parameter int SIZE_W  = 5
) (
	input  ctrl_state_t                          state,
	input  logic [((SIZE_W > $clog2(PE_ROWS+PE_COLS)) ?
	               SIZE_W : $clog2(PE_ROWS+PE_COLS)):0] count,
	input  logic [SIZE_W-1:0]                    k_size,
	output logic [PE_ROWS-1:0]                   opnd1_push_en,
	output logic [PE_ROWS-1:0]                   opnd1_pop_en,
	output logic [PE_COLS-1:0]                   opnd2_push_en,
	output logic [PE_COLS-1:0]                   opnd2_pop_en
);

	localparam int SUM_W = $clog2(PE_ROWS + PE_COLS);
	localparam int CNT_W = ((SIZE_W > SUM_W) ? SIZE_W : SUM_W) + 1;
	localparam int LANES = (PE_ROWS > PE_COLS) ? PE_ROWS : PE_COLS; // Both sides share windows

	logic             computing;
	logic             push;
	logic [CNT_W-1:0] k_ext;
	logic [LANES-1:0] pop_win;

	assign computing = (state == ST_COMPUTE);
	assign k_ext     = CNT_W'(k_size);
	assign push      = computing && (count < k_ext); // All lanes fill during the first K cycles

	// Lane i drains K entries starting i cycles late
	for (genvar i = 0; i < LANES; i++) begin : g_skew
		assign pop_win[i] = computing && (count >= CNT_W'(i)) && (count < k_ext + CNT_W'(i));
	end

	assign opnd1_push_en = {PE_ROWS{push}};
	assign opnd2_push_en = {PE_COLS{push}};
	assign opnd1_pop_en  = pop_win[PE_ROWS-1:0];
	assign opnd2_pop_en  = pop_win[PE_COLS-1:0];

endmodule

/* rtl/mm_ctrl_top.sv */
`timescale 1ns/10ps

module mm_ctrl_top
	import systolic_geom_pkg::*;
	import mm_ctrl_pkg::*;
#(
	parameter int PE_ROWS = DEF_PE_ROWS,
	parameter int PE_COLS = DEF_PE_COLS,
	parameter int SIZE_W  = DEF_SIZE_W,
	parameter int ADDR_W  = DEF_ADDR_W
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               start,
	input  logic               stall,
	input  logic [SIZE_W-1:0]  m_size,
	input  logic [SIZE_W-1:0]  k_size,
	input  logic [SIZE_W-1:0]  n_size,
	output logic [ADDR_W-1:0]  opnd1_addr,
	output logic [ADDR_W-1:0]  opnd2_addr,
	output logic [ADDR_W-1:0]  out_addr,
	output logic               out_we_n,
	output logic [PE_COLS-1:0] out_lane_en,
	output logic [PE_ROWS-1:0] opnd1_push_en,
	output logic [PE_ROWS-1:0] opnd1_pop_en,
	output logic [PE_COLS-1:0] opnd2_push_en,
	output logic [PE_COLS-1:0] opnd2_pop_en,
	output logic               is_computing,
	output logic               is_flushing,
	output logic               finished
);

	localparam int SUM_W = $clog2(PE_ROWS + PE_COLS);
	localparam int CNT_W = ((SIZE_W > SUM_W) ? SIZE_W : SUM_W) + 1;
	localparam int RW    = $clog2(PE_ROWS + 1);
	localparam int CW    = $clog2(PE_COLS + 1);

	ctrl_state_t       state;
	logic              load_job;
	logic              to_flush;
	logic              next_tile;
	logic              compute_done;
	logic              flush_done;
	logic              last_tile;
	logic [CNT_W-1:0]  count;
	logic [SIZE_W-1:0] k_job; // K as latched at start
	logic [SIZE_W-1:0] tile_row;
	logic [SIZE_W-1:0] tile_col;
	logic [SIZE_W-1:0] num_tile_rows;
	logic [SIZE_W-1:0] num_tile_cols;
	logic [RW-1:0]     act_rows;
	logic [CW-1:0]     act_cols;

	tile_fsm u_fsm (
		.CLK(CLK), .RSTn(RSTn), .start(start), .stall(stall),
		.compute_done(compute_done), .flush_done(flush_done), .last_tile(last_tile),
		.state(state), .load_job(load_job), .to_flush(to_flush), .next_tile(next_tile),
		.finished(finished), .is_computing(is_computing), .is_flushing(is_flushing)
	);

	phase_counter #(.PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W)) u_cnt (
		.CLK(CLK), .RSTn(RSTn), .stall(stall), .state(state), .load_job(load_job),
		.to_flush(to_flush), .next_tile(next_tile), .k_in(k_size),
		.act_rows(act_rows), .act_cols(act_cols), .count(count), .k_size(k_job),
		.compute_done(compute_done), .flush_done(flush_done)
	);

	tile_sequencer #(.PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W)) u_seq (
		.CLK(CLK), .RSTn(RSTn), .load_job(load_job), .next_tile(next_tile),
		.m_in(m_size), .n_in(n_size), .tile_row(tile_row), .tile_col(tile_col),
		.num_tile_rows(num_tile_rows), .num_tile_cols(num_tile_cols),
		.act_rows(act_rows), .act_cols(act_cols), .last_tile(last_tile)
	);

	sram_addr_gen #(
		.PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W), .ADDR_W(ADDR_W)
	) u_addr (
		.CLK(CLK), .RSTn(RSTn), .stall(stall), .state(state), .load_job(load_job),
		.to_flush(to_flush), .next_tile(next_tile), .count(count),
		.tile_row(tile_row), .tile_col(tile_col),
		.num_tile_rows(num_tile_rows), .num_tile_cols(num_tile_cols),
		.act_rows(act_rows), .act_cols(act_cols),
		.opnd1_addr(opnd1_addr), .opnd2_addr(opnd2_addr), .out_addr(out_addr),
		.out_we_n(out_we_n), .out_lane_en(out_lane_en)
	);

	fifo_enable_gen #(.PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W)) u_fifo (
		.state(state), .count(count), .k_size(k_job),
		.opnd1_push_en(opnd1_push_en), .opnd1_pop_en(opnd1_pop_en),
		.opnd2_push_en(opnd2_push_en), .opnd2_pop_en(opnd2_pop_en)
	);

endmodule

/* tb/tb_mm_ctrl.sv */
`timescale 1ns/10ps

module tb_mm_ctrl;

	localparam int PE_ROWS     = 4;
	localparam int PE_COLS     = 4;
	localparam int SIZE_W      = 5;
	localparam int ADDR_W      = 10;
	localparam int NUM_JOBS    = 40;
	localparam int JOB_TIMEOUT = 2000; // Cycles per job, stalls included
	localparam int PH_IDLE     = 0;
	localparam int PH_COMPUTE  = 1;
	localparam int PH_FLUSH    = 2;

	logic               CLK;
	logic               RSTn;
	logic               start;
	logic               stall;
	logic [SIZE_W-1:0]  m_size;
	logic [SIZE_W-1:0]  k_size;
	logic [SIZE_W-1:0]  n_size;
	logic [ADDR_W-1:0]  opnd1_addr;
	logic [ADDR_W-1:0]  opnd2_addr;
	logic [ADDR_W-1:0]  out_addr;
	logic               out_we_n;
	logic [PE_COLS-1:0] out_lane_en;
	logic [PE_ROWS-1:0] opnd1_push_en;
	logic [PE_ROWS-1:0] opnd1_pop_en;
	logic [PE_COLS-1:0] opnd2_push_en;
	logic [PE_COLS-1:0] opnd2_pop_en;
	logic               is_computing;
	logic               is_flushing;
	logic               finished;

	// Reference model state
	int          ph;
	int          cnt;            // Cycle within the phase
	int          tr, tc;         // Current tile
	int          nrt, nct;       // Tile counts
	int          mm, kk, nn;     // Latched job sizes
	int          job_m, job_k, job_n;
	logic [63:0] snap;           // Outputs of the previous cycle
	logic        prev_stall;

	mm_ctrl_top #(
		.PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W), .ADDR_W(ADDR_W)
	) dut_i (
		.CLK(CLK), .RSTn(RSTn), .start(start), .stall(stall),
		.m_size(m_size), .k_size(k_size), .n_size(n_size),
		.opnd1_addr(opnd1_addr), .opnd2_addr(opnd2_addr), .out_addr(out_addr),
		.out_we_n(out_we_n), .out_lane_en(out_lane_en),
		.opnd1_push_en(opnd1_push_en), .opnd1_pop_en(opnd1_pop_en),
		.opnd2_push_en(opnd2_push_en), .opnd2_pop_en(opnd2_pop_en),
		.is_computing(is_computing), .is_flushing(is_flushing), .finished(finished)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK; // 20 ns period
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("%s did not happen within %0d cycles", what, JOB_TIMEOUT);
		$display("test failed");
		$fatal(1);
	endtask

	// Rows or columns of a tile that hold real data
	function automatic int act_size(input int total, input int id, input int dim);
		int rem;
		rem = total - id * dim;
		return (rem >= dim) ? dim : rem;
	endfunction

	function automatic logic [63:0] output_snapshot();
		return {opnd1_addr, opnd2_addr, out_addr, out_we_n, out_lane_en, opnd1_push_en,
			opnd1_pop_en, opnd2_push_en, opnd2_pop_en, is_computing, is_flushing};
	endfunction

	task automatic check_outputs();
		int                 ar, ac, r, i;
		logic [PE_ROWS-1:0] e_push1, e_pop1;
		logic [PE_COLS-1:0] e_push2, e_pop2, e_lane;
		logic               e_we_n, e_fin, last;
		ar = act_size(mm, tr, PE_ROWS);
		ac = act_size(nn, tc, PE_COLS);
		last = (tr == nrt - 1) && (tc == nct - 1);
		e_push1 = '0;
		e_pop1 = '0;
		e_push2 = '0;
		e_pop2 = '0;
		e_lane = '0;
		e_we_n = 1'b1; // Idle and compute never write
		e_fin = 1'b0;
		if (ph == PH_COMPUTE) begin
			for (i = 0; i < PE_ROWS; i++) begin
				e_push1[i] = (cnt < kk);
				e_pop1[i] = (cnt >= i) && (cnt <= kk - 1 + i); // Skewed by lane
			end
			for (i = 0; i < PE_COLS; i++) begin
				e_push2[i] = (cnt < kk);
				e_pop2[i] = (cnt >= i) && (cnt <= kk - 1 + i);
			end
			compare("opnd1_addr", opnd1_addr, (tr + cnt * nrt) % (1 << ADDR_W));
			compare("opnd2_addr", opnd2_addr, (tc + cnt * nct) % (1 << ADDR_W));
		end
		if (ph == PH_FLUSH) begin
			for (i = 0; i < PE_COLS; i++)
				e_lane[i] = (i < ac);
			e_we_n = !(cnt >= PE_ROWS - ar); // Bottom ar rows only
			e_fin = (cnt == PE_ROWS - 1) && last && !stall;
			if (!e_we_n) begin
				r = cnt - (PE_ROWS - ar);
				compare("out_addr", out_addr, ((tr * PE_ROWS + r) * nct + tc) % (1 << ADDR_W));
			end
		end
		compare("is_computing", is_computing, ph == PH_COMPUTE);
		compare("is_flushing", is_flushing, ph == PH_FLUSH);
		compare("finished", finished, e_fin);
		compare("out_we_n", out_we_n, e_we_n);
		compare("out_lane_en", out_lane_en, e_lane);
		compare("opnd1_push_en", opnd1_push_en, e_push1);
		compare("opnd1_pop_en", opnd1_pop_en, e_pop1);
		compare("opnd2_push_en", opnd2_push_en, e_push2);
		compare("opnd2_pop_en", opnd2_pop_en, e_pop2);
		// A stalled cycle must leave every registered output alone
		if (prev_stall)
			compare("outputs after stall", output_snapshot(), snap);
		snap = output_snapshot();
		prev_stall = stall;
	endtask

	task automatic advance_model();
		int ar, ac;
		ar = act_size(mm, tr, PE_ROWS);
		ac = act_size(nn, tc, PE_COLS);
		if (!stall) begin
			case (ph)
				PH_IDLE: if (start) begin
					ph = PH_COMPUTE;
					cnt = 0;
					mm = m_size;
					kk = k_size;
					nn = n_size;
					tr = 0;
					tc = 0;
					nrt = (mm + PE_ROWS - 1) / PE_ROWS;
					nct = (nn + PE_COLS - 1) / PE_COLS;
				end
				PH_COMPUTE: if (cnt == kk + ar + ac - 2) begin
					ph = PH_FLUSH;
					cnt = 0;
				end else
					cnt++;
				default: if (cnt == PE_ROWS - 1) begin
					cnt = 0;
					if ((tr == nrt - 1) && (tc == nct - 1))
						ph = PH_IDLE; // Job done
					else begin
						ph = PH_COMPUTE;
						if (tc == nct - 1) begin
							tc = 0;
							tr++;
						end else
							tc++;
					end
				end else
					cnt++;
			endcase
		end
	endtask

	// One clock: drive, check mid cycle, then step the model
	task automatic cycle(input logic st);
		@(posedge CLK);
		#1;
		start = st;
		stall = (($urandom % 8) == 0);
		m_size = job_m[SIZE_W-1:0];
		k_size = job_k[SIZE_W-1:0];
		n_size = job_n[SIZE_W-1:0];
		@(negedge CLK);
		check_outputs();
		advance_model();
	endtask

	task automatic run_job();
		int n;
		n = 0;
		while (ph == PH_IDLE && n < JOB_TIMEOUT) begin
			cycle(1'b1); // Start held until a cycle without stall takes it
			n++;
		end
		if (ph == PH_IDLE)
			timeout_fail("job start");
		while (ph != PH_IDLE && n < JOB_TIMEOUT) begin
			cycle(1'b0);
			n++;
		end
		if (ph != PH_IDLE)
			timeout_fail("job finish");
	endtask

	initial begin
		int job;
		int gap;
		void'($urandom(32'h109d));
		RSTn = 1'b0;
		start = 1'b0;
		stall = 1'b0;
		m_size = '0;
		k_size = '0;
		n_size = '0;
		ph = PH_IDLE;
		cnt = 0;
		tr = 0;
		tc = 0;
		nrt = 0;
		nct = 0;
		mm = 0;
		kk = 0;
		nn = 0;
		job_m = 0;
		job_k = 0;
		job_n = 0;
		snap = '0;
		prev_stall = 1'b0;
		repeat (2) @(posedge CLK);
		#1 RSTn = 1'b1;
		repeat (6) cycle(1'b0); // Idle with start low
		for (job = 0; job < NUM_JOBS; job++) begin
			job_m = 1 + ($urandom % 15);
			job_n = 1 + ($urandom % 15);
			job_k = 1 + ($urandom % 8);
			run_job();
			gap = $urandom % 4;
			repeat (gap) cycle(1'b0);
		end
		$display("test passed");
		$finish;
	end

endmodule

/* mm_ctrl_top.f */
rtl/systolic_geom_pkg.sv
rtl/mm_ctrl_pkg.sv
rtl/tile_fsm.sv
rtl/phase_counter.sv
rtl/tile_sequencer.sv
rtl/sram_addr_gen.sv
rtl/fifo_enable_gen.sv
rtl/mm_ctrl_top.sv
tb/tb_mm_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mm_ctrl
RTL_TOP   ?= mm_ctrl_top
FLIST     ?= mm_ctrl_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
